// ==== common/load_pkg.sv ====
package load_pkg;

    // ********************
    // Widths
    // ********************
    parameter int LINE_WIDTH = 512;
    parameter int ADDR_WIDTH = 48;

    typedef logic [LINE_WIDTH-1:0] line_t;
    typedef logic [ADDR_WIDTH-1:0] addr_t;

    // Line counts and offsets
    typedef logic [31:0] count_t;

    // ********************
    // Configuration and DMA command
    // ********************
    typedef struct packed {
        count_t [2:0] index_offset;
        count_t       base_offset;
        addr_t        base_addr;
        count_t       length;
        logic         multiline;
        logic         trigger_dma;
    } load_cfg_t;

    typedef struct packed {
        addr_t  addr;
        count_t length;
        logic   multiline;
    } dma_cmd_t;

    // Request length codes of the DMA engine
    typedef enum logic [1:0] {
        BURST_1 = 2'd0,
        BURST_2 = 2'd1,
        BURST_4 = 2'd3
    } burst_e;

    typedef enum logic [2:0] {
        REQ_IDLE,
        REQ_ACCUMULATE,
        REQ_DMA_TRIGGER,
        REQ_READ,
        REQ_DONE
    } req_state_e;

endpackage

// ==== hw/load_config.sv ====
`timescale 1ns/1ps

module load_config (
    input  logic                clk,
    input  logic                internal_reset,
    input  logic                op_start,
    input  load_pkg::load_cfg_t cfg,
    input  logic                busy,
    output logic                addr_ready,
    output load_pkg::addr_t     start_addr,
    output load_pkg::count_t    length,
    output logic                multiline,
    output logic                trigger_dma
);

    logic                               active;
    logic [1:0]                         step;
    logic                               accept;
    load_pkg::count_t [2:0]             index_offset;
    load_pkg::count_t                   running_offset;
    logic [load_pkg::ADDR_WIDTH-33:0]   upper_addr;

    // No new operation until the previous one has been handed on
    assign accept = op_start && !busy && !active && !addr_ready;

    assign start_addr = {upper_addr, running_offset};

    // ********************
    // Sequencing
    // ********************
    always_ff @(posedge clk)
    begin
        if (internal_reset)
        begin
            active     <= 1'b0;
            step       <= 2'd0;
            addr_ready <= 1'b0;
        end
        else
        begin
            addr_ready <= 1'b0;
            if (accept)
            begin
                active <= 1'b1;
                step   <= 2'd0;
            end
            else if (active)
            begin
                step <= step + 2'd1;
                // Third offset added this cycle
                if (step == 2'd2)
                begin
                    active     <= 1'b0;
                    addr_ready <= 1'b1;
                end
            end
        end
    end

    // ********************
    // Configuration and address sum
    // ********************
    always_ff @(posedge clk)
    begin
        if (accept)
        begin
            index_offset   <= cfg.index_offset;
            upper_addr     <= cfg.base_addr[load_pkg::ADDR_WIDTH-1:32];
            running_offset <= cfg.base_addr[31:0] + cfg.base_offset;
            length         <= cfg.length;
            multiline      <= cfg.multiline;
            trigger_dma    <= cfg.trigger_dma;
        end
        else if (active)
        begin
            // Low 32 bits wrap, upper part untouched
            running_offset <= running_offset + index_offset[step];
        end
    end

endmodule

// ==== request/load_requester.sv ====
`timescale 1ns/1ps

module load_requester #(
    parameter int LOG2_PREFETCH_SIZE = 4
) (
    input  logic                        clk,
    input  logic                        internal_reset,
    input  logic                        addr_ready,
    input  load_pkg::addr_t             start_addr,
    input  load_pkg::count_t            length,
    input  logic                        multiline,
    input  logic                        trigger_dma,
    input  logic                        dma_idle,
    input  logic                        dma_active,
    input  logic                        rx_valid,
    input  logic [LOG2_PREFETCH_SIZE:0] fifo_count,
    output logic                        dma_start,
    output load_pkg::dma_cmd_t          dma_cmd,
    output logic                        rd_req,
    output load_pkg::burst_e            rd_len,
    output logic                        busy
);

    localparam int PREFETCH_SIZE = 1 << LOG2_PREFETCH_SIZE;

    load_pkg::req_state_e state;
    load_pkg::count_t     requested;
    load_pkg::count_t     received;
    load_pkg::count_t     in_flight;
    load_pkg::count_t     credit;
    load_pkg::count_t     remaining;
    load_pkg::count_t     burst_lines;
    load_pkg::burst_e     burst;
    logic                 dma_want;
    logic                 req_fire;

    // ********************
    // Credit and burst choice
    // ********************
    assign in_flight = requested - received;
    assign credit    = load_pkg::count_t'(PREFETCH_SIZE)
                     - load_pkg::count_t'(fifo_count) - in_flight;
    assign remaining = length - requested;

    // Largest burst that fits both the remaining lines and the credit
    always_comb
    begin
        if (multiline && remaining >= 32'd4 && credit >= 32'd4)
        begin
            burst       = load_pkg::BURST_4;
            burst_lines = 32'd4;
        end
        else if (multiline && remaining >= 32'd2 && credit >= 32'd2)
        begin
            burst       = load_pkg::BURST_2;
            burst_lines = 32'd2;
        end
        else
        begin
            burst       = load_pkg::BURST_1;
            burst_lines = 32'd1;
        end
    end

    assign req_fire = (state == load_pkg::REQ_READ) && dma_active
                   && (remaining != 32'd0) && (credit >= burst_lines);
    assign rd_req   = req_fire;
    assign rd_len   = burst;

    // Command goes out as soon as the engine is idle
    assign dma_want  = (state == load_pkg::REQ_DMA_TRIGGER)
                    || (state == load_pkg::REQ_ACCUMULATE && trigger_dma && length != 32'd0);
    assign dma_start = dma_want && dma_idle;

    assign busy = (state != load_pkg::REQ_IDLE);

    // ********************
    // Request FSM
    // ********************
    always_ff @(posedge clk)
    begin
        if (internal_reset)
        begin
            state <= load_pkg::REQ_IDLE;
        end
        else
        begin
            case (state)
                load_pkg::REQ_IDLE:
                begin
                    if (addr_ready)
                    begin
                        state <= load_pkg::REQ_ACCUMULATE;
                    end
                end
                // Address sum is final here
                load_pkg::REQ_ACCUMULATE:
                begin
                    if (length == 32'd0)
                    begin
                        state <= load_pkg::REQ_DONE;
                    end
                    else if (!trigger_dma || dma_idle)
                    begin
                        state <= load_pkg::REQ_READ;
                    end
                    else
                    begin
                        state <= load_pkg::REQ_DMA_TRIGGER;
                    end
                end
                load_pkg::REQ_DMA_TRIGGER:
                begin
                    if (dma_idle)
                    begin
                        state <= load_pkg::REQ_READ;
                    end
                end
                load_pkg::REQ_READ:
                begin
                    if (requested == length)
                    begin
                        state <= load_pkg::REQ_DONE;
                    end
                end
                // Wait until every line has landed and drained
                load_pkg::REQ_DONE:
                begin
                    if (received == length && fifo_count == '0)
                    begin
                        state <= load_pkg::REQ_IDLE;
                    end
                end
                default:
                begin
                    state <= load_pkg::REQ_IDLE;
                end
            endcase
        end
    end

    // Requested and received line counts
    always_ff @(posedge clk)
    begin
        if (internal_reset)
        begin
            requested <= '0;
            received  <= '0;
        end
        else if (state == load_pkg::REQ_IDLE && addr_ready)
        begin
            requested <= '0;
            received  <= '0;
        end
        else
        begin
            if (req_fire)
            begin
                requested <= requested + burst_lines;
            end
            if (rx_valid)
            begin
                received <= received + 32'd1;
            end
        end
    end

    always_ff @(posedge clk)
    begin
        if (state == load_pkg::REQ_IDLE && addr_ready)
        begin
            dma_cmd.addr      <= start_addr;
            dma_cmd.length    <= length;
            dma_cmd.multiline <= multiline;
        end
    end

endmodule

// ==== receive/prefetch_fifo.sv ====
`timescale 1ns/1ps

module prefetch_fifo #(
    parameter int LOG2_DEPTH = 4,
    parameter int WIDTH      = 512
) (
    input  logic                  clk,
    input  logic                  internal_reset,
    input  logic                  we,
    input  logic [WIDTH-1:0]      wdata,
    input  logic                  re,
    output logic [WIDTH-1:0]      rdata,
    output logic                  rd_valid,
    output logic                  empty,
    output logic [LOG2_DEPTH:0]   count
);

    localparam int DEPTH = 1 << LOG2_DEPTH;

    logic [WIDTH-1:0]       mem [DEPTH];
    logic [LOG2_DEPTH-1:0]  wr_ptr;
    logic [LOG2_DEPTH-1:0]  rd_ptr;
    logic                   do_read;

    assign empty   = (count == '0);
    assign do_read = re && !empty;

    // ********************
    // Storage
    // ********************
    always_ff @(posedge clk)
    begin
        if (we)
        begin
            mem[wr_ptr] <= wdata;
        end
        // Registered read port
        if (do_read)
        begin
            rdata <= mem[rd_ptr];
        end
    end

    // ********************
    // Pointers and occupancy
    // ********************
    always_ff @(posedge clk)
    begin
        if (internal_reset)
        begin
            wr_ptr   <= '0;
            rd_ptr   <= '0;
            count    <= '0;
            rd_valid <= 1'b0;
        end
        else
        begin
            rd_valid <= do_read;
            if (we)
            begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (do_read)
            begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            case ({we, do_read})
                2'b10: count <= count + 1'b1;
                2'b01: count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

endmodule

// ==== receive/line_forwarder.sv ====
`timescale 1ns/1ps

module line_forwarder (
    input  logic             clk,
    input  logic             internal_reset,
    input  logic             addr_ready,
    input  load_pkg::count_t length,
    input  logic             fifo_empty,
    output logic             fifo_re,
    input  logic             fifo_rd_valid,
    input  load_pkg::line_t  fifo_rdata,
    input  logic             line_almostfull,
    output logic             line_valid,
    output load_pkg::line_t  line_data,
    output logic             op_done
);

    logic             armed;
    load_pkg::count_t forwarded;

    // At most two lines still in flight once almost-full rises
    assign fifo_re = !fifo_empty && !line_almostfull;

    // ********************
    // Output strobe and done
    // ********************
    always_ff @(posedge clk)
    begin
        if (internal_reset)
        begin
            armed      <= 1'b0;
            forwarded  <= '0;
            line_valid <= 1'b0;
            op_done    <= 1'b0;
        end
        else
        begin
            line_valid <= fifo_rd_valid;
            op_done    <= 1'b0;
            if (fifo_rd_valid)
            begin
                forwarded <= forwarded + 32'd1;
            end
            if (addr_ready)
            begin
                armed     <= 1'b1;
                forwarded <= '0;
            end
            else if (armed && forwarded == length)
            begin
                // Last line went out last cycle, or there was none
                armed   <= 1'b0;
                op_done <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk)
    begin
        if (fifo_rd_valid)
        begin
            line_data <= fifo_rdata;
        end
    end

endmodule

// ==== hw/load_unit.sv ====
`timescale 1ns/1ps

module load_unit #(
    parameter int LOG2_PREFETCH_SIZE = 4
) (
    input  logic                clk,
    input  logic                internal_reset,
    input  logic                op_start,
    input  load_pkg::load_cfg_t cfg,
    output logic                dma_start,
    output load_pkg::dma_cmd_t  dma_cmd,
    input  logic                dma_idle,
    input  logic                dma_active,
    output logic                rd_req,
    output load_pkg::burst_e    rd_len,
    input  logic                rx_valid,
    input  load_pkg::line_t     rx_data,
    output logic                line_valid,
    output load_pkg::line_t     line_data,
    input  logic                line_almostfull,
    output logic                op_done
);

    logic                          busy;
    logic                          addr_ready;
    load_pkg::addr_t               start_addr;
    load_pkg::count_t              length;
    logic                          multiline;
    logic                          trigger_dma;

    // Prefetch FIFO side
    logic                          fifo_re;
    logic                          fifo_rd_valid;
    load_pkg::line_t               fifo_rdata;
    logic                          fifo_empty;
    logic [LOG2_PREFETCH_SIZE:0]   fifo_count;

    load_config config_inst (
        .clk,
        .internal_reset,
        .op_start,
        .cfg,
        .busy,
        .addr_ready,
        .start_addr,
        .length,
        .multiline,
        .trigger_dma
    );

    load_requester #(
        .LOG2_PREFETCH_SIZE(LOG2_PREFETCH_SIZE)
    ) requester_inst (
        .clk,
        .internal_reset,
        .addr_ready,
        .start_addr,
        .length,
        .multiline,
        .trigger_dma,
        .dma_idle,
        .dma_active,
        .rx_valid,
        .fifo_count,
        .dma_start,
        .dma_cmd,
        .rd_req,
        .rd_len,
        .busy
    );

    prefetch_fifo #(
        .LOG2_DEPTH(LOG2_PREFETCH_SIZE),
        .WIDTH(load_pkg::LINE_WIDTH)
    ) fifo_inst (
        .clk,
        .internal_reset,
        .we(rx_valid),
        .wdata(rx_data),
        .re(fifo_re),
        .rdata(fifo_rdata),
        .rd_valid(fifo_rd_valid),
        .empty(fifo_empty),
        .count(fifo_count)
    );

    line_forwarder forwarder_inst (
        .clk,
        .internal_reset,
        .addr_ready,
        .length,
        .fifo_empty,
        .fifo_re,
        .fifo_rd_valid,
        .fifo_rdata,
        .line_almostfull,
        .line_valid,
        .line_data,
        .op_done
    );

endmodule

// ==== test/load_unit_sva.sv ====
`timescale 1ns/1ps

module load_unit_sva #(
    parameter int LOG2_PREFETCH_SIZE = 4
) (
    input logic                        clk,
    input logic                        internal_reset,
    input logic                        rx_valid,
    input logic [LOG2_PREFETCH_SIZE:0] fifo_count,
    input logic                        dma_active,
    input logic                        rd_req,
    input load_pkg::burst_e            rd_len,
    input logic                        op_done
);

    localparam int DEPTH = 1 << LOG2_PREFETCH_SIZE;

    // Lines requested from the engine and not yet returned
    int outstanding;

    always_ff @(posedge clk)
    begin
        if (internal_reset)
        begin
            outstanding <= 0;
        end
        else
        begin
            outstanding <= outstanding + (rd_req ? int'(rd_len) + 1 : 0)
                         - (rx_valid ? 1 : 0);
        end
    end

    // ********************
    // FIFO and request rules
    // ********************
    fifo_no_overflow: assert property (
        @(posedge clk) disable iff (internal_reset)
        !(rx_valid && int'(fifo_count) == DEPTH)
    ) else $error("Prefetch FIFO written while full");

    // A burst must fit the free FIFO entries left after the lines in flight
    req_within_credit: assert property (
        @(posedge clk) disable iff (internal_reset)
        rd_req |-> dma_active && (outstanding + int'(fifo_count) + int'(rd_len) + 1 <= DEPTH)
    ) else $error("rd_req issued while dma_active is low or beyond the FIFO credit");

    // Done is a single-cycle pulse
    done_single_pulse: assert property (
        @(posedge clk) disable iff (internal_reset)
        op_done |=> !op_done
    ) else $error("op_done high in two consecutive cycles");

endmodule

bind load_unit load_unit_sva #(
    .LOG2_PREFETCH_SIZE(LOG2_PREFETCH_SIZE)
) sva_inst (
    .clk,
    .internal_reset,
    .rx_valid,
    .fifo_count,
    .dma_active,
    .rd_req,
    .rd_len,
    .op_done
);

// ==== test/tb_load_unit.sv ====
`timescale 1ns/1ps

module tb_load_unit;

    localparam int NUM_OPS        = 12;
    localparam int TIMEOUT_CYCLES = NUM_OPS * 400;
    localparam int LOG2_PREFETCH  = 4;

    logic                clk;
    logic                internal_reset;
    logic                op_start;
    load_pkg::load_cfg_t cfg;
    logic                dma_start;
    load_pkg::dma_cmd_t  dma_cmd;
    logic                dma_idle;
    logic                dma_active;
    logic                rd_req;
    load_pkg::burst_e    rd_len;
    logic                rx_valid;
    load_pkg::line_t     rx_data;
    logic                line_valid;
    load_pkg::line_t     line_data;
    logic                line_almostfull;
    logic                op_done;

    // Values applied after the next rising edge
    logic                next_op_start;
    load_pkg::load_cfg_t next_cfg;
    logic                next_dma_idle;
    logic                next_dma_active;
    logic                next_rx_valid;
    load_pkg::line_t     next_rx_data;
    logic                next_almostfull;

    logic [31:0]         seed;
    int                  cycle_count;

    // Model state of the running operation
    load_pkg::load_cfg_t op_cfg;
    load_pkg::addr_t     exp_addr;
    logic                backpressure;
    logic                dma_started;
    int                  idle_wait;
    int                  dma_starts;
    int                  rd_reqs;
    int                  req_lines;
    int                  rx_index;
    int                  fwd_index;
    int                  af_strobes;
    int                  done_seen;
    int                  start_cycle;
    int                  done_cycle;
    int                  pending[$];

    load_unit #(
        .LOG2_PREFETCH_SIZE(LOG2_PREFETCH)
    ) uut (
        .clk,
        .internal_reset,
        .op_start,
        .cfg,
        .dma_start,
        .dma_cmd,
        .dma_idle,
        .dma_active,
        .rd_req,
        .rd_len,
        .rx_valid,
        .rx_data,
        .line_valid,
        .line_data,
        .line_almostfull,
        .op_done
    );

    always #2 clk = ~clk;

    always @(posedge clk)
    begin
        cycle_count++;
        if (cycle_count >= TIMEOUT_CYCLES)
        begin
            $display("Timeout after %0d cycles, an operation never finished", cycle_count);
            $display("TEST RESULT: FAIL");
            $fatal(1, "Simulation stopped by the cycle limit");
        end
    end

    // ********************
    // Helpers
    // ********************
    function automatic logic [31:0] next_random();
        seed = seed * 32'd1664525 + 32'd1013904223;
        return seed;
    endfunction

    // Low 32 bits wrap, upper bits straight from base_addr
    function automatic load_pkg::addr_t expected_start_addr(input load_pkg::load_cfg_t c);
        logic [31:0] low;
        low = c.base_addr[31:0] + c.base_offset + c.index_offset[0]
            + c.index_offset[1] + c.index_offset[2];
        return {c.base_addr[load_pkg::ADDR_WIDTH-1:32], low};
    endfunction

    function automatic load_pkg::line_t line_pattern(input load_pkg::addr_t a, input int i);
        logic [63:0] word;
        word = 64'(a + load_pkg::addr_t'(i));
        return {(load_pkg::LINE_WIDTH/64){word}};
    endfunction

    function automatic int lines_in_burst(input load_pkg::burst_e b);
        case (b)
            load_pkg::BURST_1: return 1;
            load_pkg::BURST_2: return 2;
            load_pkg::BURST_4: return 4;
            default: return 0;
        endcase
    endfunction

    task automatic check_value(input logic [load_pkg::LINE_WIDTH-1:0] actual,
                               input logic [load_pkg::LINE_WIDTH-1:0] expected,
                               input string what);
        if (actual !== expected)
        begin
            $display("mismatch at %0t: %s, got %0h, expected %0h",
                     $time, what, actual, expected);
            $display("TEST RESULT: FAIL");
            $fatal(1, "Value check failed");
        end
    endtask

    task automatic apply_inputs();
        op_start        = next_op_start;
        cfg             = next_cfg;
        dma_idle        = next_dma_idle;
        dma_active      = next_dma_active;
        rx_valid        = next_rx_valid;
        rx_data         = next_rx_data;
        line_almostfull = next_almostfull;
    endtask

    // ********************
    // Monitor and DMA engine model
    // ********************
    task automatic monitor_cycle();
        int lines;
        int delay;
        int k;
        if (dma_start)
        begin
            dma_starts++;
            dma_started = 1'b1;
            check_value(dma_cmd.addr, exp_addr, "dma_cmd address");
            check_value(dma_cmd.length, op_cfg.length, "dma_cmd length");
            check_value(dma_cmd.multiline, op_cfg.multiline, "dma_cmd multiline");
            next_dma_idle   = 1'b0;
            next_dma_active = 1'b1;
        end
        else if (op_cfg.trigger_dma && !dma_started)
        begin
            // Engine becomes idle after a random wait
            if (idle_wait > 0)
            begin
                idle_wait--;
            end
            else
            begin
                next_dma_idle = 1'b1;
            end
        end

        if (rd_req)
        begin
            lines = lines_in_burst(rd_len);
            rd_reqs++;
            check_value(lines != 0, 1'b1, "rd_len code");
            if (!op_cfg.multiline)
            begin
                check_value(rd_len, load_pkg::BURST_1, "rd_len without multiline");
            end
            req_lines += lines;
            delay = 1 + int'((next_random() >> 16) % 32'd6);
            for (k = 0; k < lines; k++)
            begin
                pending.push_back(cycle_count + delay);
            end
        end

        if (!line_almostfull)
        begin
            af_strobes = 0;
        end
        if (line_valid)
        begin
            check_value(fwd_index < int'(op_cfg.length), 1'b1, "line strobe beyond length");
            check_value(line_data, line_pattern(exp_addr, fwd_index), "line data");
            fwd_index++;
            if (line_almostfull)
            begin
                af_strobes++;
                check_value(af_strobes > 2, 1'b0, "line strobes after almost-full");
            end
        end

        if (op_done)
        begin
            done_seen++;
            done_cycle = cycle_count;
            check_value(fwd_index, op_cfg.length, "lines before op_done");
        end

        // One returned line per cycle, in request order
        next_rx_valid = 1'b0;
        if (pending.size() > 0 && pending[0] <= cycle_count + 1)
        begin
            void'(pending.pop_front());
            next_rx_valid = 1'b1;
            next_rx_data  = line_pattern(exp_addr, rx_index);
            rx_index++;
        end

        if (!backpressure)
        begin
            next_almostfull = 1'b0;
        end
        else if (line_almostfull)
        begin
            next_almostfull = ((next_random() >> 16) % 32'd3) != 0;
        end
        else
        begin
            next_almostfull = ((next_random() >> 16) % 32'd5) == 0;
        end
    endtask

    task automatic run_cycle();
        @(posedge clk);
        #0.5;
        apply_inputs();
        @(negedge clk);
        monitor_cycle();
    endtask

    // ********************
    // Operations
    // ********************
    task automatic draw_config(input int op, output load_pkg::load_cfg_t c, output logic bp);
        logic [31:0] r;
        logic [31:0] upper;
        c.index_offset[0] = next_random();
        c.index_offset[1] = next_random();
        c.index_offset[2] = next_random();
        c.base_offset     = next_random();
        upper             = next_random();
        c.base_addr       = {upper[31:16], next_random()};
        r                 = next_random();
        c.length          = (r >> 8) % 32'd41;
        c.multiline       = r[31];
        c.trigger_dma     = r[30];
        bp                = r[29];
        // A few fixed corners
        if (op == 0)
        begin
            c.length      = 32'd0;
            c.trigger_dma = 1'b1;
        end
        else if (op == 1)
        begin
            c.trigger_dma = 1'b0;
            c.length      = 32'd1 + c.length % 32'd40;
        end
        else if (op == 2)
        begin
            c.multiline = 1'b1;
            c.length    = 32'd40;
            bp          = 1'b1;
        end
    endtask

    task automatic start_op(input load_pkg::load_cfg_t c, input logic bp);
        op_cfg       = c;
        exp_addr     = expected_start_addr(c);
        backpressure = bp;
        dma_started  = 1'b0;
        dma_starts   = 0;
        rd_reqs      = 0;
        req_lines    = 0;
        rx_index     = 0;
        fwd_index    = 0;
        af_strobes   = 0;
        done_seen    = 0;
        idle_wait    = int'((next_random() >> 16) % 32'd8);
        next_op_start   = 1'b1;
        next_cfg        = c;
        next_dma_idle   = !c.trigger_dma;
        next_dma_active = !c.trigger_dma;
    endtask

    task automatic finish_op_checks();
        int exp_starts;
        exp_starts = (op_cfg.trigger_dma && op_cfg.length != 0) ? 1 : 0;
        check_value(done_seen, 1, "op_done pulses");
        check_value(dma_starts, exp_starts, "dma_start pulses");
        check_value(req_lines, op_cfg.length, "requested lines");
        check_value(rx_index, op_cfg.length, "returned lines");
        check_value(fwd_index, op_cfg.length, "forwarded lines");
        check_value(pending.size(), 0, "lines still pending in DMA model");
        if (op_cfg.length == 0)
        begin
            check_value(rd_reqs, 0, "rd_req for empty load");
            check_value(done_cycle - start_cycle, 6, "op_done latency for empty load");
        end
    endtask

    initial
    begin
        load_pkg::load_cfg_t c;
        logic                bp;
        clk             = 1'b0;
        cycle_count     = 0;
        seed            = 32'h501c;
        internal_reset  = 1'b1;
        op_start        = 1'b0;
        cfg             = '0;
        dma_idle        = 1'b1;
        dma_active      = 1'b0;
        rx_valid        = 1'b0;
        rx_data         = '0;
        line_almostfull = 1'b0;
        next_op_start   = 1'b0;
        next_cfg        = '0;
        next_dma_idle   = 1'b1;
        next_dma_active = 1'b0;
        next_rx_valid   = 1'b0;
        next_rx_data    = '0;
        next_almostfull = 1'b0;
        op_cfg          = '0;

        repeat (5) @(posedge clk);
        #0.5;
        internal_reset = 1'b0;

        for (int op = 0; op < NUM_OPS; op++)
        begin
            draw_config(op, c, bp);
            start_op(c, bp);
            run_cycle();
            start_cycle   = cycle_count;
            next_op_start = 1'b0;
            while (done_seen == 0)
            begin
                run_cycle();
            end
            // Engine released, consumer ready again
            backpressure    = 1'b0;
            next_dma_active = 1'b0;
            next_dma_idle   = 1'b1;
            repeat (3) run_cycle();
            finish_op_checks();
        end

        $display("TEST RESULT: PASS");
        $finish;
    end

endmodule

// ==== files.f ====
common/load_pkg.sv
hw/load_config.sv
request/load_requester.sv
receive/prefetch_fifo.sv
receive/line_forwarder.sv
hw/load_unit.sv
test/load_unit_sva.sv
test/tb_load_unit.sv

// ==== run.sh ====
#!/bin/sh
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal -j 0 \
    --top-module tb_load_unit -f files.f -o Vtb_load_unit

status=0
./obj_dir/Vtb_load_unit > sim.log 2>&1 || status=$?
cat sim.log

if grep -q "TEST RESULT: FAIL" sim.log; then
    echo "Simulation failed"
    exit 1
fi

if [ "$status" -ne 0 ] || ! grep -q "TEST RESULT: PASS" sim.log; then
    echo "Simulation ended without a pass result"
    exit 1
fi

echo "Simulation passed"
